//--- source/pulse_pkg.sv
package pulse_pkg;

   // Gate field widths
   localparam int LEAD_W = 8;                // Gate lead before pulse 1
   localparam int BOFF_W = 16;               // Gate hold after pulse 2

   localparam int FRAME_BYTES = 5;           // 4 value bytes + control byte

   // Control byte codes
   typedef enum logic [7:0] {
      SET_DELAY  = 8'd0,
      SET_PERIOD = 8'd1,
      SET_PULSE1 = 8'd2,
      SET_PULSE2 = 8'd3,
      SET_GATE   = 8'd4,
      SET_ECHO   = 8'd5
   } cmd_e;

   // Value word, read whole or as gate fields
   typedef union packed {
      logic [31:0] word;
      struct packed {
         logic [BOFF_W-1:0] block_off;       // Bits 31:16
         logic [LEAD_W-1:0] lead;            // Bits 15:8
         logic [5:0]        spare;
         logic              block_en;        // Bit 1
         logic              pump;            // Bit 0, pulse 1 enable
      } gate;
   } value_u;

   // Reset defaults, all in clk cycles
   localparam logic [31:0] DEF_PERIOD = 32'd201000;
   localparam logic [31:0] DEF_P1WIDTH = 32'd30;
   localparam logic [31:0] DEF_P2WIDTH = 32'd30;
   localparam logic [31:0] DEF_DELAY = 32'd200;
   localparam logic [LEAD_W-1:0] DEF_LEAD = 8'd50;
   localparam logic [BOFF_W-1:0] DEF_BLOCK_OFF = 16'd100;
   localparam logic DEF_PUMP = 1'b1;
   localparam logic DEF_BLOCK_EN = 1'b1;
   localparam logic DEF_ECHO = 1'b1;         // Echo pulse on

endpackage

//--- source/pulse_cfg_if.sv
interface pulse_cfg_if;
   import pulse_pkg::*;

   // Live pulse parameter set
   logic [31:0]       period;                // Cycles per repetition
   logic [31:0]       p1width;
   logic [31:0]       delay;                 // Gap between pulse 1 and pulse 2
   logic [31:0]       p2width;
   logic [LEAD_W-1:0] lead;                  // Gate open to pulse 1
   logic [BOFF_W-1:0] block_off;             // Pulse 2 end to gate close
   logic              pump;                  // Pulse 1 enable
   logic              block_en;              // Gate enable
   logic              echo;                  // Pulse 2 enable

   // Controller side drives everything
   modport ctrl (
      output period, p1width, delay, p2width,
      output lead, block_off,
      output pump, block_en, echo
   );

   // Sequencer only reads
   modport seq (
      input period, p1width, delay, p2width,
      input lead, block_off,
      input pump, block_en, echo
   );

endinterface

//--- source/uart_rx.sv
module uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       rx,
   output logic       rx_valid,
   output logic [7:0] rx_data,
   output logic       rx_error
);

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam logic [CNT_W-1:0] HALF_M1 = CNT_W'(CLKS_PER_BIT / 2 - 1);
   localparam logic [CNT_W-1:0] FULL_M1 = CNT_W'(CLKS_PER_BIT - 1);

   // FSM states
   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_START = 2'd1;
   localparam logic [1:0] S_DATA = 2'd2;
   localparam logic [1:0] S_STOP = 2'd3;

   logic             rx_meta, rx_sync, rx_prev;
   logic [1:0]       state;
   logic [CNT_W-1:0] baud_cnt;
   logic [2:0]       bit_cnt;
   logic [7:0]       shift_q;

   // Two-flop synchronizer plus one stage for edge detect
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rx_meta <= 1'b1;                    // Line idles high
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= S_IDLE;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         rx_valid <= 1'b0;
         rx_error <= 1'b0;
      end else begin
         rx_valid <= 1'b0;                   // Strobes by default
         rx_error <= 1'b0;
         baud_cnt <= baud_cnt + 1'b1;
         case (state)
            S_IDLE: begin
               baud_cnt <= '0;
               // Falling edge only, a line stuck low after a bad stop bit is ignored
               if (rx_prev && !rx_sync) state <= S_START;
            end
            S_START: if (baud_cnt == HALF_M1) begin
               baud_cnt <= '0;
               bit_cnt  <= '0;
               state    <= rx_sync ? S_IDLE : S_DATA; // Glitch rejected
            end
            S_DATA: if (baud_cnt == FULL_M1) begin
               baud_cnt <= '0;
               bit_cnt  <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7) state <= S_STOP;
            end
            S_STOP: if (baud_cnt == FULL_M1) begin
               rx_valid <= rx_sync;          // Good stop bit
               rx_error <= !rx_sync;         // Framing error
               state    <= S_IDLE;
            end
         endcase
      end
   end

   // Data bits arrive LSB first, sampled mid-bit
   always_ff @(posedge clk) begin
      if (state == S_DATA && baud_cnt == FULL_M1) shift_q <= {rx_sync, shift_q[7:1]};
   end

   assign rx_data = shift_q;

endmodule

//--- source/uart_tx.sv
module uart_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       tx_valid,
   input  logic [7:0] tx_data,
   output logic       tx,
   output logic       tx_credit
);

   localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam logic [CNT_W-1:0] FULL_M1 = CNT_W'(CLKS_PER_BIT - 1);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_START = 2'd1;
   localparam logic [1:0] S_DATA = 2'd2;
   localparam logic [1:0] S_STOP = 2'd3;

   logic [1:0]       state;
   logic [CNT_W-1:0] baud_cnt;
   logic [2:0]       bit_cnt;
   logic [7:0]       shift_q;                // The one buffer slot
   logic             bit_end;

   assign bit_end = (baud_cnt == FULL_M1);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= S_IDLE;
         baud_cnt  <= '0;
         bit_cnt   <= '0;
         tx        <= 1'b1;                  // Idle high
         tx_credit <= 1'b0;
      end else begin
         tx_credit <= 1'b0;
         baud_cnt  <= bit_end ? '0 : baud_cnt + 1'b1;
         case (state)
            S_IDLE: begin
               baud_cnt <= '0;
               if (tx_valid) begin
                  tx    <= 1'b0;             // Start bit
                  state <= S_START;
               end
            end
            S_START: if (bit_end) begin
               tx      <= shift_q[0];
               bit_cnt <= '0;
               state   <= S_DATA;
            end
            S_DATA: if (bit_end) begin
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 3'd7) begin
                  tx    <= 1'b1;             // Stop bit
                  state <= S_STOP;
               end else begin
                  tx <= shift_q[1];          // Next bit, shift happens this edge
               end
            end
            S_STOP: if (bit_end) begin
               tx_credit <= 1'b1;            // Slot free again
               state     <= S_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE && tx_valid) shift_q <= tx_data;
      else if (state == S_DATA && bit_end) shift_q <= {1'b0, shift_q[7:1]};
   end

endmodule

//--- source/pulse_control.sv
module pulse_control (
   input  logic       clk,
   input  logic       arst_n,
   input  logic       rx_valid,
   input  logic [7:0] rx_data,
   input  logic       rx_error,
   input  logic       tx_credit,
   output logic       tx_valid,
   output logic [7:0] tx_data,
   pulse_cfg_if.ctrl  cfg
);
   import pulse_pkg::*;

   logic [2:0] byte_cnt;                     // Position in the frame
   value_u     value_q;                      // Value bytes, LSB first
   logic [7:0] sum_q;                        // Running checksum
   logic [7:0] reply_q;                      // Pending reply byte
   logic       pend_q;
   logic [1:0] credit_cnt;                   // Free slots in uart_tx
   logic       last_byte;
   logic       frame_end;
   logic       send;

   assign last_byte = (byte_cnt == 3'(FRAME_BYTES - 1));
   assign frame_end = rx_valid && last_byte;   // Control byte arriving
   assign send = pend_q && (credit_cnt != 2'd0);

   // Frame byte counter, dropped back to zero on a framing error
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         byte_cnt <= '0;
      end else if (rx_error) begin
         byte_cnt <= '0;
      end else if (rx_valid) begin
         byte_cnt <= last_byte ? 3'd0 : byte_cnt + 3'd1;
      end
   end

   // Value assembly and checksum
   always_ff @(posedge clk) begin
      if (rx_valid && !last_byte) begin
         value_q.word[{byte_cnt[1:0], 3'b000} +: 8] <= rx_data;
         sum_q <= (byte_cnt == 3'd0) ? rx_data : sum_q + rx_data; // Restart on byte 0
      end
   end

   // Parameter registers, written one cycle after the control byte
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg.period    <= DEF_PERIOD;
         cfg.p1width   <= DEF_P1WIDTH;
         cfg.delay     <= DEF_DELAY;
         cfg.p2width   <= DEF_P2WIDTH;
         cfg.lead      <= DEF_LEAD;
         cfg.block_off <= DEF_BLOCK_OFF;
         cfg.pump      <= DEF_PUMP;
         cfg.block_en  <= DEF_BLOCK_EN;
         cfg.echo      <= DEF_ECHO;
      end else if (frame_end) begin
         case (cmd_e'(rx_data))
            SET_DELAY:  cfg.delay   <= value_q.word;
            SET_PERIOD: cfg.period  <= value_q.word;
            SET_PULSE1: cfg.p1width <= value_q.word;
            SET_PULSE2: cfg.p2width <= value_q.word;
            SET_GATE: begin
               cfg.pump      <= value_q.gate.pump;
               cfg.block_en  <= value_q.gate.block_en;
               cfg.lead      <= value_q.gate.lead;
               cfg.block_off <= value_q.gate.block_off;
            end
            SET_ECHO: cfg.echo <= value_q.word[0];
            default: ;                       // Unknown code, reply only
         endcase
      end
   end

   // Reply queue, a newer frame overwrites a waiting checksum
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pend_q     <= 1'b0;
         tx_valid   <= 1'b0;
         credit_cnt <= 2'd1;                 // uart_tx starts empty
      end else begin
         tx_valid <= send;
         if (frame_end) pend_q <= 1'b1;
         else if (send) pend_q <= 1'b0;
         case ({send, tx_credit})
            2'b10: credit_cnt <= credit_cnt - 2'd1;
            2'b01: credit_cnt <= credit_cnt + 2'd1;
            default: ;                       // None or both, no change
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (frame_end) reply_q <= sum_q;
      if (send) tx_data <= reply_q;
   end

endmodule

//--- source/pulse_sequencer.sv
module pulse_sequencer (
   input  logic      clk,
   input  logic      arst_n,
   pulse_cfg_if.seq  cfg,
   output logic      pulse_out,
   output logic      block_out
);

   logic        run_q;                       // Set from first period start on
   logic [31:0] cnt_q;                       // Cycle within period
   logic        load;                        // Next cycle is a period start

   // Shadow config as window edges
   logic [31:0] last_q;
   logic [31:0] p1_on, p1_off;
   logic [31:0] p2_on, p2_off;
   logic [31:0] blk_end;
   logic        pump_q, echo_q, blk_en_q;

   logic [31:0] p1_end_c, p2_on_c, p2_end_c;

   assign load = !run_q || (cnt_q == last_q);

   // Edge sums from the live config
   assign p1_end_c = 32'(cfg.lead) + cfg.p1width;
   assign p2_on_c = p1_end_c + cfg.delay;
   assign p2_end_c = p2_on_c + cfg.p2width;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         run_q <= 1'b0;
         cnt_q <= '0;
      end else begin
         run_q <= 1'b1;
         cnt_q <= load ? 32'd0 : cnt_q + 32'd1;
      end
   end

   // Latched once per period so a change never cuts a pulse short
   always_ff @(posedge clk) begin
      if (load) begin
         last_q   <= (cfg.period < 32'd2) ? 32'd1 : cfg.period - 32'd1; // Min period 2
         p1_on    <= 32'(cfg.lead);
         p1_off   <= p1_end_c;
         p2_on    <= p2_on_c;
         p2_off   <= p2_end_c;
         blk_end  <= p2_end_c + 32'(cfg.block_off);
         pump_q   <= cfg.pump;
         echo_q   <= cfg.echo;
         blk_en_q <= cfg.block_en;
      end
   end

   // Window compares
   assign pulse_out = run_q &&
                      ((pump_q && cnt_q >= p1_on && cnt_q < p1_off) ||
                       (echo_q && cnt_q >= p2_on && cnt_q < p2_off));
   assign block_out = run_q && blk_en_q && (cnt_q < blk_end); // Gate from cycle 0

endmodule

//--- source/pulse_top.sv
module pulse_top #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic clk,
   input  logic arst_n,
   input  logic rx,
   output logic tx,
   output logic pulse_out,
   output logic block_out,
   output logic rx_error
);

   logic       rx_valid;
   logic [7:0] rx_data;
   logic       tx_valid;
   logic [7:0] tx_data;
   logic       tx_credit;

   pulse_cfg_if i_cfg ();                    // Live parameters

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
      .clk      (clk),
      .arst_n   (arst_n),
      .rx       (rx),
      .rx_valid (rx_valid),
      .rx_data  (rx_data),
      .rx_error (rx_error)
   );

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
      .clk       (clk),
      .arst_n    (arst_n),
      .tx_valid  (tx_valid),
      .tx_data   (tx_data),
      .tx        (tx),
      .tx_credit (tx_credit)
   );

   pulse_control i_control (
      .clk       (clk),
      .arst_n    (arst_n),
      .rx_valid  (rx_valid),
      .rx_data   (rx_data),
      .rx_error  (rx_error),
      .tx_credit (tx_credit),
      .tx_valid  (tx_valid),
      .tx_data   (tx_data),
      .cfg       (i_cfg.ctrl)
   );

   pulse_sequencer i_sequencer (
      .clk       (clk),
      .arst_n    (arst_n),
      .cfg       (i_cfg.seq),
      .pulse_out (pulse_out),
      .block_out (block_out)
   );

endmodule

//--- verif/pulse_top_chk.sv
module pulse_top_chk (
   input logic                        clk,
   input logic                        arst_n,
   input logic                        tx_valid,
   input logic                        tx_credit,
   input logic [1:0]                  credit_cnt,
   input logic                        pulse_out,
   input logic                        load,
   input logic [31:0]                 cnt,
   input logic [pulse_pkg::LEAD_W-1:0] lead,
   input logic [31:0]                 p1width,
   input logic [31:0]                 delay,
   input logic [31:0]                 p2width,
   input logic                        pump,
   input logic                        echo
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [1:0]  free_q;                      // Slots seen free from the bus side
   logic [31:0] w1_on, w1_off;
   logic [31:0] w2_on, w2_off;
   logic        pump_q, echo_q;

   // Credits counted from the handshake alone
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         free_q <= 2'd1;
      end else begin
         free_q <= free_q - {1'b0, tx_valid} + {1'b0, tx_credit};
      end
   end

   // Windows rebuilt from the raw fields at each period start
   always_ff @(posedge clk) begin
      if (load) begin
         w1_on  <= 32'(lead);
         w1_off <= 32'(lead) + p1width;
         w2_on  <= 32'(lead) + p1width + delay;
         w2_off <= 32'(lead) + p1width + delay + p2width;
         pump_q <= pump;
         echo_q <= echo;
      end
   end

   a_send_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
      tx_valid |-> free_q != 2'd0)
      else $error("tx_valid sent without a credit");

   a_credit_max: assert property (@(posedge clk) disable iff (!arst_n)
      credit_cnt <= 2'd1)
      else $error("Credit count above one");

   a_pulse_window: assert property (@(posedge clk) disable iff (!arst_n)
      pulse_out |-> ((pump_q && cnt >= w1_on && cnt < w1_off) ||
                     (echo_q && cnt >= w2_on && cnt < w2_off)))
      else $error("pulse_out high outside its windows");

endmodule

bind pulse_control pulse_top_chk i_ctrl_chk (
   .clk(clk), .arst_n(arst_n), .tx_valid(tx_valid), .tx_credit(tx_credit),
   .credit_cnt(credit_cnt), .pulse_out(1'b0), .load(1'b0), .cnt(32'd0),
   .lead(8'd0), .p1width(32'd0), .delay(32'd0), .p2width(32'd0),
   .pump(1'b0), .echo(1'b0)
);

bind pulse_sequencer pulse_top_chk i_seq_chk (
   .clk(clk), .arst_n(arst_n), .tx_valid(1'b0), .tx_credit(1'b0),
   .credit_cnt(2'd1), .pulse_out(pulse_out), .load(load), .cnt(cnt_q),
   .lead(cfg.lead), .p1width(cfg.p1width), .delay(cfg.delay),
   .p2width(cfg.p2width), .pump(cfg.pump), .echo(cfg.echo)
);

//--- verif/tb_pulse_top.sv
module tb_pulse_top;
   timeunit 1ns;
   timeprecision 100ps;
   import pulse_pkg::*;

   localparam int CPB = 16;                  // Clocks per UART bit
   localparam int RECV_MAX = 1200;           // Whole frame plus reply latency
   localparam int WAIT_MAX = 250000;         // Longer than the reset period

   logic clk, arst_n, rx;
   logic tx, pulse_out, block_out, rx_error;

   int          errors = 0;
   int          timeouts = 0;
   logic [31:0] lfsr = 32'ha66a_6a53;

   // Expected parameter set, starts at the reset values
   int exp_period = 201000;
   int exp_lead = 50;
   int exp_w1 = 30;
   int exp_d = 200;
   int exp_w2 = 30;
   int exp_boff = 100;
   int exp_pump = 1;
   int exp_ben = 1;
   int exp_echo = 1;

   // Edges of the last measured period
   int rise[$];
   int fall[$];
   int blk_cnt;

   pulse_top #(.CLKS_PER_BIT(CPB)) i_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .rx        (rx),
      .tx        (tx),
      .pulse_out (pulse_out),
      .block_out (block_out),
      .rx_error  (rx_error)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                 // 8 ns period
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);             // One step per bit
         v = {v[30:0], lfsr[0]};
      end
   endtask

   task automatic report_mismatch(input string name, input int got, input int exp);
      errors++;
      $display("FAILED %0t %s: got %0d, expected %0d", $time, name, got, exp);
   endtask

   task automatic drive_bit(input logic v);
      @(posedge clk);
      rx <= v;
      repeat (CPB - 1) @(posedge clk);
   endtask

   // Host side of the serial line, 8N1
   task automatic uart_send_byte(input logic [7:0] b, input logic stop);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) drive_bit(b[i]);
      drive_bit(stop);
      if (!stop) drive_bit(1'b1);            // Back to idle after a bad stop bit
   endtask

   task automatic uart_recv_byte(output logic [7:0] b, output bit got, input int max_cycles);
      int n;
      n = 0;
      got = 1'b0;
      b = '0;
      @(negedge clk);
      while (tx && n < max_cycles) begin
         @(negedge clk);
         n++;
      end
      if (!tx) begin
         repeat (CPB / 2) @(negedge clk);    // Middle of the start bit
         for (int i = 0; i < 8; i++) begin
            repeat (CPB) @(negedge clk);
            b[i] = tx;
         end
         repeat (CPB) @(negedge clk);
         if (tx !== 1'b1) report_mismatch("tx stop bit", int'(tx), 1);
         got = 1'b1;
      end
   endtask

   // Frame out, reply in, checksum compared
   task automatic send_frame(input logic [31:0] value, input logic [7:0] cmd);
      logic [7:0] reply, exp_sum;
      bit         got;
      exp_sum = value[7:0] + value[15:8] + value[23:16] + value[31:24];
      fork
         begin
            for (int i = 0; i < 4; i++) uart_send_byte(value[8*i +: 8], 1'b1);
            uart_send_byte(cmd, 1'b1);
         end
         uart_recv_byte(reply, got, RECV_MAX);
      join
      if (!got) begin
         timeouts++;
         $display("Timeout: no reply to frame with control byte %0d", cmd);
      end else if (reply != exp_sum) begin
         report_mismatch("tx reply", int'(reply), int'(exp_sum));
      end
   endtask

   task automatic send_gate();
      logic [31:0] w;
      w = {exp_boff[15:0], exp_lead[7:0], 6'd0, exp_ben[0], exp_pump[0]};
      send_frame(w, SET_GATE);
   endtask

   // lead_ref < 0 syncs on the gate, else on a pulse 1 rise at cycle lead_ref
   task automatic measure_period(input int lead_ref, output bit ok, output logic wrap);
      int   n, c, c_end, low_run, need_low;
      bit   found;
      logic now, p_prev;
      rise.delete();
      fall.delete();
      blk_cnt = 0;
      ok = 1'b0;
      wrap = 1'b0;
      n = 0;
      low_run = 0;
      found = 1'b0;
      need_low = (lead_ref < 0) ? 1 : exp_d + 1; // Skips the gap before pulse 2
      while (!found && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
         now = (lead_ref < 0) ? block_out : pulse_out;
         found = now && (low_run >= need_low);
         low_run = now ? 0 : low_run + 1;
      end
      if (!found) begin
         timeouts++;
         $display("Timeout: no period start seen at %0t", $time);
      end else begin
         c = (lead_ref < 0) ? 0 : lead_ref;
         c_end = c + exp_period;             // One full period from the sync edge
         p_prev = 1'b0;
         while (c < c_end) begin
            if (pulse_out && !p_prev) rise.push_back(c);
            if (!pulse_out && p_prev) fall.push_back(c);
            if (block_out) blk_cnt++;
            p_prev = pulse_out;
            c++;
            @(negedge clk);
         end
         wrap = (lead_ref < 0) ? block_out : pulse_out; // Same edge one period on
         ok = 1'b1;
      end
   endtask

   // One period against the window rule
   task automatic check_pattern();
      bit   ok;
      logic wrap;
      int   n_exp, idx, p2_on;
      if (!exp_ben) measure_period(exp_lead, ok, wrap); // May still hold the old config
      measure_period(exp_ben ? -1 : exp_lead, ok, wrap);
      if (ok) begin
         n_exp = exp_pump + exp_echo;
         p2_on = exp_lead + exp_w1 + exp_d;
         idx = 0;
         if (wrap !== 1'b1)
            report_mismatch(exp_ben ? "block_out at next period" : "pulse_out at next period",
                            int'(wrap), 1);
         if (rise.size() != n_exp || fall.size() != n_exp) begin
            report_mismatch("pulse_out pulse count", rise.size(), n_exp);
         end else begin
            if (exp_pump) begin
               if (rise[0] != exp_lead) report_mismatch("pulse_out p1 rise", rise[0], exp_lead);
               if (fall[0] != exp_lead + exp_w1)
                  report_mismatch("pulse_out p1 fall", fall[0], exp_lead + exp_w1);
               idx = 1;
            end
            if (exp_echo) begin
               if (rise[idx] != p2_on) report_mismatch("pulse_out p2 rise", rise[idx], p2_on);
               if (fall[idx] != p2_on + exp_w2)
                  report_mismatch("pulse_out p2 fall", fall[idx], p2_on + exp_w2);
            end
         end
         if (blk_cnt != (exp_ben ? p2_on + exp_w2 + exp_boff : 0))
            report_mismatch("block_out length", blk_cnt,
                            exp_ben ? p2_on + exp_w2 + exp_boff : 0);
      end
   endtask

   task automatic test_defaults();
      exp_period = 2000;
      send_frame(32'd2000, SET_PERIOD);
      check_pattern();                       // 50 / 30, then 230 later / 30, gate 410
   endtask

   task automatic test_timing();
      logic [31:0] r;
      rand_bits(6, r);
      exp_d = 20 + int'(r);
      send_frame(exp_d, SET_DELAY);
      rand_bits(5, r);
      exp_w1 = 1 + int'(r);
      send_frame(exp_w1, SET_PULSE1);
      rand_bits(5, r);
      exp_w2 = 1 + int'(r);
      send_frame(exp_w2, SET_PULSE2);
      check_pattern();
   endtask

   task automatic test_checksum();
      logic [31:0] r;
      for (int i = 0; i < 3; i++) begin
         rand_bits(32, r);
         send_frame(r, 8'd9);                // Unknown code, reply only
      end
      check_pattern();
   endtask

   task automatic test_gate();
      exp_pump = 0;
      send_gate();
      check_pattern();
      exp_pump = 1;
      exp_lead = 80;
      exp_boff = 300;
      send_gate();
      check_pattern();
      exp_ben = 0;
      send_gate();
      check_pattern();
      exp_ben = 1;
      send_gate();
   endtask

   task automatic test_echo();
      exp_echo = 0;
      send_frame(32'd0, SET_ECHO);
      check_pattern();
      exp_echo = 1;
      send_frame(32'd1, SET_ECHO);
      check_pattern();
   endtask

   task automatic wait_rx_error();
      int n;
      n = 0;
      @(negedge clk);
      while (!rx_error && n < 400) begin
         @(negedge clk);
         n++;
      end
      if (!rx_error) begin
         errors++;
         $display("rx_error did not pulse after a low stop bit at %0t", $time);
      end
   endtask

   task automatic test_framing();
      logic [7:0] b;
      bit         got;
      uart_send_byte(8'h12, 1'b1);
      uart_send_byte(8'h34, 1'b1);
      fork
         uart_send_byte(8'h56, 1'b0);        // Stop bit held low
         wait_rx_error();
      join
      uart_recv_byte(b, got, 600);
      if (got) begin
         errors++;
         $display("Unexpected reply 0x%02h after a framing error", b);
      end
      exp_d = 150;
      send_frame(32'd150, SET_DELAY);
      check_pattern();
   endtask

   initial begin
      rx = 1'b1;
      arst_n = 1'b0;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      test_defaults();
      test_timing();
      test_checksum();
      test_gate();
      test_echo();
      test_framing();
      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- project.f
source/pulse_pkg.sv
source/pulse_cfg_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/pulse_control.sv
source/pulse_sequencer.sv
source/pulse_top.sv
verif/pulse_top_chk.sv
verif/tb_pulse_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pulse_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -qF '*** PASSED ***' $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
